// ==== common/fu_pkg.sv ====
package fu_pkg;

	localparam int XLEN        = 64;
	localparam int INST_W      = 32;
	localparam int PRF_IDX_W   = 6;
	localparam int ROB_IDX_W   = 5;
	localparam int SHAMT_W     = 6;  // shift amount from opb

	localparam logic [PRF_IDX_W-1:0] ZERO_REG = '0;  // no destination

	localparam int MULT_STAGES  = 4;
	localparam int MULT_CHUNK_W = XLEN / MULT_STAGES;  // multiplier bits per stage

	// instruction fields
	localparam int ALU_OP_LSB   = 5;
	localparam int ALU_OP_W     = 4;
	localparam int BR_COND_LSB  = 26;
	localparam int BR_COND_W    = 3;
	localparam int BR_DISP_LSB  = 0;
	localparam int BR_DISP_W    = 21;
	localparam int MEM_DISP_LSB = 0;
	localparam int MEM_DISP_W   = 16;

	localparam int FU_SEL_W = 3;

	typedef enum logic [FU_SEL_W-1:0] {
		FU_NONE      = 3'd0,
		FU_ALU       = 3'd1,
		FU_BR_UNCOND = 3'd2,
		FU_BR_COND   = 3'd3,
		FU_MULT      = 3'd4,
		FU_LOAD      = 3'd5,
		FU_STORE     = 3'd6
	} fu_sel_e;

	typedef enum logic [ALU_OP_W-1:0] {
		ADD   = 4'h0,
		SUB   = 4'h1,
		AND   = 4'h2,
		OR    = 4'h3,
		XOR   = 4'h4,
		SLL   = 4'h5,
		SRL   = 4'h6,
		CMPEQ = 4'h7,
		CMPLT = 4'h8  // signed
	} alu_op_e;

	// opa tested against zero
	typedef enum logic [BR_COND_W-1:0] {
		BEQ = 3'd0,
		BNE = 3'd1,
		BLT = 3'd2,
		BGE = 3'd3
	} br_cond_e;

endpackage

// ==== common/fu_iss_if.sv ====
`timescale 1ns/100ps

interface fu_iss_if;
	import fu_pkg::*;

	logic [XLEN-1:0]      opa;
	logic [XLEN-1:0]      opb;
	logic [INST_W-1:0]    inst;
	logic [XLEN-1:0]      npc;
	logic [PRF_IDX_W-1:0] dest_tag;
	logic [ROB_IDX_W-1:0] rob_idx;

	modport src (
		output opa, opb, inst, npc, dest_tag, rob_idx
	);

	// every unit sees the same bundle, qualified by its own start
	modport unit (
		input opa, opb, inst, npc, dest_tag, rob_idx
	);

endinterface

// ==== common/fu_wb_if.sv ====
`timescale 1ns/100ps

interface fu_wb_if;
	import fu_pkg::*;

	logic                 req;  // level, held until gnt
	logic                 wr_en;
	logic [PRF_IDX_W-1:0] dest_tag;
	logic [ROB_IDX_W-1:0] rob_idx;
	logic [XLEN-1:0]      value;
	logic                 gnt;

	modport unit (
		output req, wr_en, dest_tag, rob_idx, value,
		input  gnt
	);

	modport arb (
		input  req, wr_en, dest_tag, rob_idx, value,
		output gnt
	);

endinterface

// ==== verilog/fu_alu.sv ====
`timescale 1ns/100ps

module fu_alu (
	input  logic   clk,
	input  logic   reset_i,
	input  logic   start_i,
	input  logic   recovery_i,
	fu_iss_if.unit iss,
	fu_wb_if.unit  wb
);
	import fu_pkg::*;

	alu_op_e              op;
	logic [XLEN-1:0]      res;
	logic [XLEN-1:0]      res_r;
	logic [PRF_IDX_W-1:0] tag_r;
	logic [ROB_IDX_W-1:0] rob_r;
	logic                 vld_r;

	assign op = alu_op_e'(iss.inst[ALU_OP_LSB +: ALU_OP_W]);

	always_comb begin
		case (op)
			ADD:     res = iss.opa + iss.opb;
			SUB:     res = iss.opa - iss.opb;
			AND:     res = iss.opa & iss.opb;
			OR:      res = iss.opa | iss.opb;
			XOR:     res = iss.opa ^ iss.opb;
			SLL:     res = iss.opa << iss.opb[SHAMT_W-1:0];
			SRL:     res = iss.opa >> iss.opb[SHAMT_W-1:0];
			CMPEQ:   res = {{(XLEN-1){1'b0}}, iss.opa == iss.opb};
			CMPLT:   res = {{(XLEN-1){1'b0}}, $signed(iss.opa) < $signed(iss.opb)};
			default: res = '0;
		endcase
	end

	// held until the bus takes it
	always_ff @(posedge clk) begin
		if (reset_i || recovery_i) begin
			vld_r <= 1'b0;
		end else if (start_i) begin
			vld_r <= 1'b1;
		end else if (wb.gnt) begin
			vld_r <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			res_r <= res;
			tag_r <= iss.dest_tag;
			rob_r <= iss.rob_idx;
		end
	end

	assign wb.req      = vld_r;
	assign wb.wr_en    = (tag_r != ZERO_REG);
	assign wb.dest_tag = tag_r;
	assign wb.rob_idx  = rob_r;
	assign wb.value    = res_r;

endmodule

// ==== verilog/fu_br.sv ====
`timescale 1ns/100ps

module fu_br (
	input  logic                         clk,
	input  logic                         reset_i,
	input  logic                         start_i,
	input  logic                         uncond_i,
	input  logic                         recovery_i,
	fu_iss_if.unit                       iss,
	fu_wb_if.unit                        wb,
	output logic                         br_done_o,
	output logic                         br_taken_o,
	output logic [fu_pkg::XLEN-1:0]      br_target_o,
	output logic [fu_pkg::ROB_IDX_W-1:0] br_idx_o
);
	import fu_pkg::*;

	br_cond_e             cond;
	logic                 cond_ok;
	logic [XLEN-1:0]      target;
	logic                 rep_r;   // report pulse
	logic                 req_r;
	logic                 taken_r;
	logic                 wr_en_r;
	logic [XLEN-1:0]      target_r;
	logic [XLEN-1:0]      link_r;
	logic [PRF_IDX_W-1:0] tag_r;
	logic [ROB_IDX_W-1:0] rob_r;

	assign cond = br_cond_e'(iss.inst[BR_COND_LSB +: BR_COND_W]);

	always_comb begin
		case (cond)
			BEQ:     cond_ok = (iss.opa == '0);
			BNE:     cond_ok = (iss.opa != '0);
			BLT:     cond_ok = ($signed(iss.opa) < 0);
			BGE:     cond_ok = ($signed(iss.opa) >= 0);
			default: cond_ok = 1'b0;
		endcase
	end

	// npc + disp * 4
	assign target = iss.npc + {{(XLEN-BR_DISP_W-2){iss.inst[BR_DISP_LSB+BR_DISP_W-1]}},
		iss.inst[BR_DISP_LSB +: BR_DISP_W], 2'b00};

	always_ff @(posedge clk) begin
		if (reset_i || recovery_i) begin
			rep_r <= 1'b0;
			req_r <= 1'b0;
		end else begin
			rep_r <= start_i;  // never waits for the bus
			if (start_i)
				req_r <= 1'b1;
			else if (wb.gnt)
				req_r <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			taken_r  <= uncond_i | cond_ok;
			wr_en_r  <= uncond_i && (iss.dest_tag != ZERO_REG);  // link only
			target_r <= target;
			link_r   <= iss.npc;
			tag_r    <= iss.dest_tag;
			rob_r    <= iss.rob_idx;
		end
	end

	assign br_done_o   = rep_r;
	assign br_taken_o  = taken_r;
	assign br_target_o = target_r;
	assign br_idx_o    = rob_r;

	assign wb.req      = req_r;
	assign wb.wr_en    = wr_en_r;
	assign wb.dest_tag = tag_r;
	assign wb.rob_idx  = rob_r;
	assign wb.value    = link_r;

endmodule

// ==== verilog/fu_mult.sv ====
`timescale 1ns/100ps

module fu_mult (
	input  logic   clk,
	input  logic   reset_i,
	input  logic   start_i,
	input  logic   recovery_i,
	fu_iss_if.unit iss,
	fu_wb_if.unit  wb
);
	import fu_pkg::*;

	localparam int LAST = MULT_STAGES - 1;

	logic [MULT_STAGES-1:0] vld_q;
	logic [XLEN-1:0]        acc_q [MULT_STAGES];
	logic [XLEN-1:0]        a_q   [MULT_STAGES-1];
	logic [XLEN-1:0]        b_q   [MULT_STAGES-1];
	logic [PRF_IDX_W-1:0]   tag_q [MULT_STAGES];
	logic [ROB_IDX_W-1:0]   rob_q [MULT_STAGES];
	logic                   frz;

	// whole pipe stops while the product waits for the bus
	assign frz = vld_q[LAST] & ~wb.gnt;

	always_ff @(posedge clk) begin
		if (reset_i || recovery_i) begin
			vld_q <= '0;
		end else if (!frz) begin
			vld_q <= {vld_q[LAST-1:0], start_i};
		end
	end

	// one chunk of opb per stage, accumulated into the low 64 bits
	always_ff @(posedge clk) begin
		if (!frz) begin
			acc_q[0] <= iss.opa * iss.opb[MULT_CHUNK_W-1:0];
			a_q[0]   <= iss.opa;
			b_q[0]   <= iss.opb;
			tag_q[0] <= iss.dest_tag;
			rob_q[0] <= iss.rob_idx;
			for (int k = 1; k < MULT_STAGES; k++) begin
				acc_q[k] <= acc_q[k-1] +
					((a_q[k-1] * b_q[k-1][k*MULT_CHUNK_W +: MULT_CHUNK_W]) << (k*MULT_CHUNK_W));
				tag_q[k] <= tag_q[k-1];
				rob_q[k] <= rob_q[k-1];
				if (k < LAST) begin
					a_q[k] <= a_q[k-1];
					b_q[k] <= b_q[k-1];
				end
			end
		end
	end

	assign wb.req      = vld_q[LAST];
	assign wb.wr_en    = (tag_q[LAST] != ZERO_REG);
	assign wb.dest_tag = tag_q[LAST];
	assign wb.rob_idx  = rob_q[LAST];
	assign wb.value    = acc_q[LAST];

endmodule

// ==== verilog/fu_ldst.sv ====
`timescale 1ns/100ps

module fu_ldst (
	input  logic                    clk,
	input  logic                    reset_i,
	input  logic                    start_i,
	input  logic                    store_i,
	input  logic                    recovery_i,
	fu_iss_if.unit                  iss,
	fu_wb_if.unit                   wb,
	output logic                    mem_rd_en_o,
	output logic                    mem_wr_en_o,
	output logic [fu_pkg::XLEN-1:0] mem_addr_o,
	output logic [fu_pkg::XLEN-1:0] mem_wr_data_o,
	input  logic [fu_pkg::XLEN-1:0] mem_rd_data_i
);
	import fu_pkg::*;

	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		LD_REQ  = 2'd1,
		LD_WAIT = 2'd2,
		DONE    = 2'd3
	} ldst_state_e;

	ldst_state_e          state;
	ldst_state_e          nxt_state;
	logic [XLEN-1:0]      addr;
	logic [XLEN-1:0]      addr_r;
	logic [XLEN-1:0]      st_data_r;
	logic [XLEN-1:0]      ld_data_r;
	logic [PRF_IDX_W-1:0] tag_r;
	logic [ROB_IDX_W-1:0] rob_r;
	logic                 st_r;
	logic                 wr_pulse;

	assign addr = iss.opb + {{(XLEN-MEM_DISP_W){iss.inst[MEM_DISP_LSB+MEM_DISP_W-1]}},
		iss.inst[MEM_DISP_LSB +: MEM_DISP_W]};

	always_comb begin
		nxt_state = state;
		case (state)
			LD_REQ:  nxt_state = LD_WAIT;
			LD_WAIT: nxt_state = wb.gnt ? IDLE : DONE;
			DONE:    if (wb.gnt) nxt_state = IDLE;
			default: ;
		endcase
		if (start_i)
			nxt_state = store_i ? DONE : LD_REQ;  // store done right away
	end

	always_ff @(posedge clk) begin
		if (reset_i || recovery_i) begin
			state    <= IDLE;
			wr_pulse <= 1'b0;
		end else begin
			state    <= nxt_state;
			wr_pulse <= start_i & store_i;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			addr_r    <= addr;
			st_data_r <= iss.opa;
			tag_r     <= iss.dest_tag;
			rob_r     <= iss.rob_idx;
			st_r      <= store_i;
		end
		if (state == LD_WAIT)
			ld_data_r <= mem_rd_data_i;  // kept in case the bus is busy
	end

	assign mem_rd_en_o   = (state == LD_REQ);
	assign mem_wr_en_o   = wr_pulse;
	assign mem_addr_o    = addr_r;
	assign mem_wr_data_o = st_data_r;

	// read data sits on the port during LD_WAIT
	assign wb.req      = (state == LD_WAIT) || (state == DONE);
	assign wb.wr_en    = ~st_r && (tag_r != ZERO_REG);
	assign wb.dest_tag = tag_r;
	assign wb.rob_idx  = rob_r;
	assign wb.value    = (state == LD_WAIT) ? mem_rd_data_i : ld_data_r;

endmodule

// ==== verilog/fu_cdb_arb.sv ====
`timescale 1ns/100ps

module fu_cdb_arb (
	fu_wb_if.arb                         alu,
	fu_wb_if.arb                         br,
	fu_wb_if.arb                         mult,
	fu_wb_if.arb                         ldst,
	input  logic                         recovery_i,
	output logic                         done_o,
	output logic [fu_pkg::ROB_IDX_W-1:0] idx_o,
	output logic                         cdb_vld_o,
	output logic [fu_pkg::PRF_IDX_W-1:0] cdb_tag_o,
	output logic [fu_pkg::XLEN-1:0]      value_o,
	output logic                         stall_o
);
	import fu_pkg::*;

	logic any_req;
	logic sel_wr;

	assign any_req = br.req | ldst.req | alu.req | mult.req;

	// br > ldst > alu > mult
	always_comb begin
		br.gnt    = 1'b0;
		ldst.gnt  = 1'b0;
		alu.gnt   = 1'b0;
		mult.gnt  = 1'b0;
		sel_wr    = 1'b0;
		cdb_tag_o = ZERO_REG;
		idx_o     = '0;
		value_o   = '0;
		if (br.req) begin
			br.gnt    = 1'b1;
			sel_wr    = br.wr_en;
			cdb_tag_o = br.dest_tag;
			idx_o     = br.rob_idx;
			value_o   = br.value;
		end else if (ldst.req) begin
			ldst.gnt  = 1'b1;
			sel_wr    = ldst.wr_en;
			cdb_tag_o = ldst.dest_tag;
			idx_o     = ldst.rob_idx;
			value_o   = ldst.value;
		end else if (alu.req) begin
			alu.gnt   = 1'b1;
			sel_wr    = alu.wr_en;
			cdb_tag_o = alu.dest_tag;
			idx_o     = alu.rob_idx;
			value_o   = alu.value;
		end else if (mult.req) begin
			mult.gnt  = 1'b1;
			sel_wr    = mult.wr_en;
			cdb_tag_o = mult.dest_tag;
			idx_o     = mult.rob_idx;
			value_o   = mult.value;
		end
	end

	assign done_o    = any_req & ~recovery_i;  // flushed results never complete
	assign cdb_vld_o = sel_wr & ~recovery_i;
	assign stall_o   = ($countones({br.req, ldst.req, alu.req, mult.req}) > 1);

endmodule

// ==== verilog/fu_main.sv ====
`timescale 1ns/100ps

module fu_main (
	input  logic                            clk,
	input  logic                            reset_i,

	input  logic                            rs2fu_iss_vld_i,
	input  fu_pkg::fu_sel_e                 rs2fu_sel_i,
	input  logic [fu_pkg::INST_W-1:0]       rs2fu_IR_i,
	input  logic [fu_pkg::XLEN-1:0]         prf2fu_ra_value_i,
	input  logic [fu_pkg::XLEN-1:0]         prf2fu_rb_value_i,
	input  logic [fu_pkg::XLEN-1:0]         rob2fu_NPC_i,
	input  logic [fu_pkg::PRF_IDX_W-1:0]    rs2fu_dest_tag_i,
	input  logic [fu_pkg::ROB_IDX_W-1:0]    rs2fu_rob_idx_i,
	input  logic                            rob_br_recovery_i,
	input  logic [fu_pkg::XLEN-1:0]         mem_rd_data_i,

	output logic                            fu2rob_done_o,
	output logic [fu_pkg::ROB_IDX_W-1:0]    fu2rob_idx_o,
	output logic                            fu_cdb_vld_o,
	output logic [fu_pkg::PRF_IDX_W-1:0]    fu_cdb_tag_o,
	output logic [fu_pkg::XLEN-1:0]         fu2preg_wr_value_o,
	output logic                            fu2rob_br_done_o,
	output logic                            fu2rob_br_taken_o,
	output logic [fu_pkg::XLEN-1:0]         fu2rob_br_target_o,
	output logic [fu_pkg::ROB_IDX_W-1:0]    fu2rob_br_idx_o,
	output logic                            fu_stall_o,
	output logic                            mem_rd_en_o,
	output logic                            mem_wr_en_o,
	output logic [fu_pkg::XLEN-1:0]         mem_addr_o,
	output logic [fu_pkg::XLEN-1:0]         mem_wr_data_o
);
	import fu_pkg::*;

	logic alu_start;
	logic br_start;
	logic mult_start;
	logic ldst_start;
	logic br_uncond;
	logic ldst_store;

	fu_iss_if iss ();
	fu_wb_if  alu_wb ();
	fu_wb_if  br_wb ();
	fu_wb_if  mult_wb ();
	fu_wb_if  ldst_wb ();

	assign iss.opa      = prf2fu_ra_value_i;
	assign iss.opb      = prf2fu_rb_value_i;
	assign iss.inst     = rs2fu_IR_i;
	assign iss.npc      = rob2fu_NPC_i;
	assign iss.dest_tag = rs2fu_dest_tag_i;
	assign iss.rob_idx  = rs2fu_rob_idx_i;

	// one start per unit
	always_comb begin
		alu_start  = 1'b0;
		br_start   = 1'b0;
		mult_start = 1'b0;
		ldst_start = 1'b0;
		if (rs2fu_iss_vld_i) begin
			case (rs2fu_sel_i)
				FU_ALU:                  alu_start  = 1'b1;
				FU_BR_UNCOND, FU_BR_COND: br_start   = 1'b1;
				FU_MULT:                 mult_start = 1'b1;
				FU_LOAD, FU_STORE:       ldst_start = 1'b1;
				default: ;
			endcase
		end
	end

	assign br_uncond  = (rs2fu_sel_i == FU_BR_UNCOND);
	assign ldst_store = (rs2fu_sel_i == FU_STORE);

	fu_alu i_fu_alu (
		.clk        (clk),
		.reset_i    (reset_i),
		.start_i    (alu_start),
		.recovery_i (rob_br_recovery_i),
		.iss        (iss.unit),
		.wb         (alu_wb.unit)
	);

	fu_br i_fu_br (
		.clk         (clk),
		.reset_i     (reset_i),
		.start_i     (br_start),
		.uncond_i    (br_uncond),
		.recovery_i  (rob_br_recovery_i),
		.iss         (iss.unit),
		.wb          (br_wb.unit),
		.br_done_o   (fu2rob_br_done_o),
		.br_taken_o  (fu2rob_br_taken_o),
		.br_target_o (fu2rob_br_target_o),
		.br_idx_o    (fu2rob_br_idx_o)
	);

	fu_mult i_fu_mult (
		.clk        (clk),
		.reset_i    (reset_i),
		.start_i    (mult_start),
		.recovery_i (rob_br_recovery_i),
		.iss        (iss.unit),
		.wb         (mult_wb.unit)
	);

	fu_ldst i_fu_ldst (
		.clk           (clk),
		.reset_i       (reset_i),
		.start_i       (ldst_start),
		.store_i       (ldst_store),
		.recovery_i    (rob_br_recovery_i),
		.iss           (iss.unit),
		.wb            (ldst_wb.unit),
		.mem_rd_en_o   (mem_rd_en_o),
		.mem_wr_en_o   (mem_wr_en_o),
		.mem_addr_o    (mem_addr_o),
		.mem_wr_data_o (mem_wr_data_o),
		.mem_rd_data_i (mem_rd_data_i)
	);

	fu_cdb_arb i_fu_cdb_arb (
		.alu        (alu_wb.arb),
		.br         (br_wb.arb),
		.mult       (mult_wb.arb),
		.ldst       (ldst_wb.arb),
		.recovery_i (rob_br_recovery_i),
		.done_o     (fu2rob_done_o),
		.idx_o      (fu2rob_idx_o),
		.cdb_vld_o  (fu_cdb_vld_o),
		.cdb_tag_o  (fu_cdb_tag_o),
		.value_o    (fu2preg_wr_value_o),
		.stall_o    (fu_stall_o)
	);

endmodule

// ==== tb/fu_ref_model.svh ====
`ifndef FU_REF_MODEL_SVH
`define FU_REF_MODEL_SVH

function automatic logic [XLEN-1:0] alu_expect(input alu_op_e op, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
	logic [5:0] sh;
	sh = b[5:0];  // low 6 bits of b only
	case (op)
		ADD:     return a + b;
		SUB:     return a - b;
		AND:     return a & b;
		OR:      return a | b;
		XOR:     return a ^ b;
		SLL:     return a << sh;
		SRL:     return a >> sh;
		CMPEQ:   return (a == b) ? 64'd1 : 64'd0;
		CMPLT:   return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
		default: return '0;
	endcase
endfunction

// full product, low half kept
function automatic logic [XLEN-1:0] product(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
	logic [2*XLEN-1:0] full;
	full = a * b;
	return full[XLEN-1:0];
endfunction

function automatic logic branch_taken(input br_cond_e cond, input logic [XLEN-1:0] a,
		input logic uncond);
	logic signed [XLEN-1:0] sa;
	sa = a;
	if (uncond)
		return 1'b1;
	case (cond)
		BEQ:     return sa == 0;
		BNE:     return sa != 0;
		BLT:     return sa < 0;
		BGE:     return sa >= 0;
		default: return 1'b0;
	endcase
endfunction

function automatic logic [XLEN-1:0] branch_target(input logic [XLEN-1:0] npc,
		input logic [INST_W-1:0] inst);
	logic signed [BR_DISP_W-1:0] disp;
	logic signed [XLEN-1:0]      offs;
	disp = inst[BR_DISP_LSB +: BR_DISP_W];
	offs = disp;
	return npc + offs * 4;
endfunction

function automatic logic [XLEN-1:0] mem_address(input logic [XLEN-1:0] base,
		input logic [INST_W-1:0] inst);
	logic signed [MEM_DISP_W-1:0] disp;
	logic signed [XLEN-1:0]       offs;
	disp = inst[MEM_DISP_LSB +: MEM_DISP_W];
	offs = disp;
	return base + offs;
endfunction

// contents of a word never stored to
function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
	return {addr[XLEN/2-1:0], addr[XLEN-1:XLEN/2]} ^ 64'hc3a5_5a3c_0ff0_96e1;
endfunction

`endif

// ==== tb/tb_fu_main.sv ====
`timescale 1ns/100ps

module tb_fu_main;
	import fu_pkg::*;

	`include "fu_ref_model.svh"

	localparam int NUM_ISSUES  = 4000;
	localparam int CYCLE_LIMIT = NUM_ISSUES * 8;
	localparam int ROB_N       = 1 << ROB_IDX_W;
	localparam int LAST        = MULT_STAGES - 1;
	// write-back sources, by priority
	localparam int U_NONE = 0;
	localparam int U_BR   = 1;
	localparam int U_LDST = 2;
	localparam int U_ALU  = 3;
	localparam int U_MULT = 4;

	logic                 clk = 1'b0;
	logic                 reset_i;
	logic                 rs2fu_iss_vld_i;
	fu_sel_e              rs2fu_sel_i;
	logic [INST_W-1:0]    rs2fu_IR_i;
	logic [XLEN-1:0]      prf2fu_ra_value_i;
	logic [XLEN-1:0]      prf2fu_rb_value_i;
	logic [XLEN-1:0]      rob2fu_NPC_i;
	logic [PRF_IDX_W-1:0] rs2fu_dest_tag_i;
	logic [ROB_IDX_W-1:0] rs2fu_rob_idx_i;
	logic                 rob_br_recovery_i;
	logic [XLEN-1:0]      mem_rd_data_i;
	logic                 fu2rob_done_o;
	logic [ROB_IDX_W-1:0] fu2rob_idx_o;
	logic                 fu_cdb_vld_o;
	logic [PRF_IDX_W-1:0] fu_cdb_tag_o;
	logic [XLEN-1:0]      fu2preg_wr_value_o;
	logic                 fu2rob_br_done_o;
	logic                 fu2rob_br_taken_o;
	logic [XLEN-1:0]      fu2rob_br_target_o;
	logic [ROB_IDX_W-1:0] fu2rob_br_idx_o;
	logic                 fu_stall_o;
	logic                 mem_rd_en_o;
	logic                 mem_wr_en_o;
	logic [XLEN-1:0]      mem_addr_o;
	logic [XLEN-1:0]      mem_wr_data_o;

	// unit occupancy for the cycle being checked
	logic                   alu_v;
	logic                   br_v;
	logic                   br_rep;
	logic                   st_pulse;
	logic [MULT_STAGES-1:0] mult_v;
	int                     ld_ph;  // 0 idle, 1 read strobe, 2 result held
	logic [ROB_IDX_W-1:0]   alu_rob;
	logic [ROB_IDX_W-1:0]   br_rob;
	logic [ROB_IDX_W-1:0]   ld_rob;
	logic [ROB_IDX_W-1:0]   mult_rob [MULT_STAGES];
	logic                   rep_taken;
	logic [XLEN-1:0]        rep_target;
	logic [XLEN-1:0]        ld_addr;
	logic [XLEN-1:0]        st_data;
	int                     gnt_unit;
	logic [ROB_IDX_W-1:0]   gnt_rob;

	// instruction on the issue ports this cycle
	logic                 iss_v;
	fu_sel_e              iss_sel;
	logic [ROB_IDX_W-1:0] iss_rob;
	logic                 iss_taken;
	logic [XLEN-1:0]      iss_target;
	logic [XLEN-1:0]      iss_addr;
	logic [XLEN-1:0]      iss_data;
	logic                 rec_cur;

	logic                 inflight [ROB_N];
	logic                 exp_wr   [ROB_N];
	logic [PRF_IDX_W-1:0] exp_tag  [ROB_N];
	logic [XLEN-1:0]      exp_val  [ROB_N];
	logic [XLEN-1:0]      mem [logic [XLEN-1:0]];

	int cycles;
	int issued;
	int n_val_err;
	int n_other_err;
	int left;

	fu_main i_fu_main (.*);

	always #50 clk = ~clk;

	task automatic report_mismatch(input string sig, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		$display("[ERROR] %0t %s got %h expected %h", $time, sig, got, exp);
		n_val_err++;
	endtask

	function automatic logic [XLEN-1:0] read_word(input logic [XLEN-1:0] addr);
		if (mem.exists(addr))
			return mem[addr];
		return fill_word(addr);
	endfunction

	function automatic int count_reqs();
		return int'(br_v) + int'(ld_ph == 2) + int'(alu_v) + int'(mult_v[LAST]);
	endfunction

	function automatic bit model_busy();
		return alu_v || br_v || br_rep || st_pulse || (|mult_v) || (ld_ph != 0) || iss_v;
	endfunction

	task automatic serve_memory();
		if (mem_wr_en_o === 1'b1)
			mem[mem_addr_o] = mem_wr_data_o;
		if (mem_rd_en_o === 1'b1) begin
			mem_rd_data_i <= read_word(mem_addr_o);
			exp_val[ld_rob] = read_word(ld_addr);  // load value as the model sees it
		end
	endtask

	task automatic check_completion(input logic [ROB_IDX_W-1:0] idx);
		if (!inflight[idx]) begin
			$display("%0t: ROB index %0d completed while not in flight", $time, idx);
			n_other_err++;
		end else begin
			if (fu_cdb_vld_o !== exp_wr[idx])
				report_mismatch("fu_cdb_vld_o", fu_cdb_vld_o, exp_wr[idx]);
			if (exp_wr[idx] && fu_cdb_tag_o !== exp_tag[idx])
				report_mismatch("fu_cdb_tag_o", fu_cdb_tag_o, exp_tag[idx]);
			if (exp_wr[idx] && fu2preg_wr_value_o !== exp_val[idx])
				report_mismatch("fu2preg_wr_value_o", fu2preg_wr_value_o, exp_val[idx]);
			inflight[idx] = 1'b0;
		end
	endtask

	task automatic check_cycle();
		int  n_req;
		logic exp_done;
		n_req    = count_reqs();
		gnt_unit = U_NONE;
		gnt_rob  = '0;
		if (br_v) begin
			gnt_unit = U_BR;
			gnt_rob  = br_rob;
		end else if (ld_ph == 2) begin
			gnt_unit = U_LDST;
			gnt_rob  = ld_rob;
		end else if (alu_v) begin
			gnt_unit = U_ALU;
			gnt_rob  = alu_rob;
		end else if (mult_v[LAST]) begin
			gnt_unit = U_MULT;
			gnt_rob  = mult_rob[LAST];
		end
		exp_done = (n_req > 0) && !rec_cur;
		if (fu_stall_o !== (n_req > 1))
			report_mismatch("fu_stall_o", fu_stall_o, n_req > 1);
		if (fu2rob_done_o !== exp_done)
			report_mismatch("fu2rob_done_o", fu2rob_done_o, exp_done);
		if (exp_done && fu2rob_done_o === 1'b1) begin
			if (fu2rob_idx_o !== gnt_rob)
				report_mismatch("fu2rob_idx_o", fu2rob_idx_o, gnt_rob);
			check_completion(fu2rob_idx_o);
		end else if (fu_cdb_vld_o !== 1'b0) begin
			report_mismatch("fu_cdb_vld_o", fu_cdb_vld_o, 1'b0);
		end
		if (fu2rob_br_done_o !== br_rep)
			report_mismatch("fu2rob_br_done_o", fu2rob_br_done_o, br_rep);
		if (br_rep && fu2rob_br_taken_o !== rep_taken)
			report_mismatch("fu2rob_br_taken_o", fu2rob_br_taken_o, rep_taken);
		if (br_rep && fu2rob_br_target_o !== rep_target)
			report_mismatch("fu2rob_br_target_o", fu2rob_br_target_o, rep_target);
		if (br_rep && fu2rob_br_idx_o !== br_rob)
			report_mismatch("fu2rob_br_idx_o", fu2rob_br_idx_o, br_rob);
		if (mem_rd_en_o !== (ld_ph == 1))
			report_mismatch("mem_rd_en_o", mem_rd_en_o, ld_ph == 1);
		if (mem_wr_en_o !== st_pulse)
			report_mismatch("mem_wr_en_o", mem_wr_en_o, st_pulse);
		if ((ld_ph == 1 || st_pulse) && mem_addr_o !== ld_addr)
			report_mismatch("mem_addr_o", mem_addr_o, ld_addr);
		if (st_pulse && mem_wr_data_o !== st_data)
			report_mismatch("mem_wr_data_o", mem_wr_data_o, st_data);
	endtask

	// advance unit occupancy by one clock
	task automatic step_model();
		logic frz;
		if (rec_cur) begin
			alu_v    = 1'b0;
			br_v     = 1'b0;
			br_rep   = 1'b0;
			st_pulse = 1'b0;
			mult_v   = '0;
			ld_ph    = 0;
			foreach (inflight[i])
				inflight[i] = 1'b0;
			return;
		end
		frz = mult_v[LAST] && (gnt_unit != U_MULT);
		if (gnt_unit == U_ALU)
			alu_v = 1'b0;
		if (gnt_unit == U_BR)
			br_v = 1'b0;
		if (ld_ph == 1)
			ld_ph = 2;
		else if (ld_ph == 2 && gnt_unit == U_LDST)
			ld_ph = 0;
		if (!frz) begin
			for (int k = LAST; k > 0; k--) begin
				mult_v[k]   = mult_v[k-1];
				mult_rob[k] = mult_rob[k-1];
			end
			mult_v[0]   = iss_v && (iss_sel == FU_MULT);
			mult_rob[0] = iss_rob;
		end
		br_rep   = iss_v && (iss_sel == FU_BR_UNCOND || iss_sel == FU_BR_COND);
		st_pulse = iss_v && (iss_sel == FU_STORE);
		if (iss_v) begin
			case (iss_sel)
				FU_ALU: begin
					alu_v   = 1'b1;
					alu_rob = iss_rob;
				end
				FU_BR_UNCOND, FU_BR_COND: begin
					br_v       = 1'b1;
					br_rob     = iss_rob;
					rep_taken  = iss_taken;
					rep_target = iss_target;
				end
				FU_LOAD, FU_STORE: begin
					ld_ph   = (iss_sel == FU_STORE) ? 2 : 1;
					ld_rob  = iss_rob;
					ld_addr = iss_addr;
					st_data = iss_data;
				end
				default: ;
			endcase
		end
	endtask

	task automatic drive_next(input bit allow);
		logic [XLEN-1:0]      a;
		logic [XLEN-1:0]      b;
		logic [XLEN-1:0]      npc;
		logic [INST_W-1:0]    inst;
		logic [PRF_IDX_W-1:0] tag;
		logic [ROB_IDX_W-1:0] rob;
		fu_sel_e              sel;
		int                   disp;
		rec_cur = allow && ($urandom % 150 == 0);
		iss_v   = allow && !rec_cur && (count_reqs() <= 1) && ($urandom % 5 != 0);
		rob_br_recovery_i <= rec_cur;
		rs2fu_iss_vld_i   <= iss_v;
		if (!iss_v)
			return;
		sel = fu_sel_e'($urandom_range(6, 1));
		if ((sel == FU_LOAD || sel == FU_STORE) && ld_ph == 1)
			sel = FU_ALU;  // memory port still busy
		a    = {$urandom, $urandom};
		b    = {$urandom, $urandom};
		npc  = {$urandom, $urandom};
		inst = $urandom;
		if ($urandom % 6 == 0)
			a = '0;
		if ($urandom % 4 == 0)
			b = a;
		inst[ALU_OP_LSB +: ALU_OP_W]   = ALU_OP_W'($urandom % 9);
		inst[BR_COND_LSB +: BR_COND_W] = BR_COND_W'($urandom % 4);
		if (sel == FU_LOAD || sel == FU_STORE) begin
			// small window so loads hit earlier stores
			b    = 64'h8000 + 64'($urandom % 8) * 64;
			disp = int'($urandom_range(31, 0)) * 8 - 128;
			inst[MEM_DISP_LSB +: MEM_DISP_W] = disp[MEM_DISP_W-1:0];
		end
		tag = ($urandom % 8 == 0) ? ZERO_REG : PRF_IDX_W'($urandom);
		do
			rob = ROB_IDX_W'($urandom);
		while (inflight[rob]);
		inflight[rob] = 1'b1;
		exp_tag[rob]  = tag;
		exp_wr[rob]   = (tag != ZERO_REG);
		iss_sel    = sel;
		iss_rob    = rob;
		iss_taken  = branch_taken(br_cond_e'(inst[BR_COND_LSB +: BR_COND_W]), a,
			sel == FU_BR_UNCOND);
		iss_target = branch_target(npc, inst);
		iss_addr   = mem_address(b, inst);
		iss_data   = a;
		case (sel)
			FU_ALU:       exp_val[rob] = alu_expect(alu_op_e'(inst[ALU_OP_LSB +: ALU_OP_W]), a, b);
			FU_MULT:      exp_val[rob] = product(a, b);
			FU_BR_UNCOND: exp_val[rob] = npc;  // link
			FU_BR_COND, FU_STORE: exp_wr[rob] = 1'b0;
			default: ;
		endcase
		rs2fu_sel_i       <= sel;
		rs2fu_IR_i        <= inst;
		prf2fu_ra_value_i <= a;
		prf2fu_rb_value_i <= b;
		rob2fu_NPC_i      <= npc;
		rs2fu_dest_tag_i  <= tag;
		rs2fu_rob_idx_i   <= rob;
		issued++;
	endtask

	task automatic run_cycle(input bit allow);
		@(posedge clk);
		cycles++;
		serve_memory();
		check_cycle();
		step_model();
		drive_next(allow);
	endtask

	initial begin
		void'($urandom(32'h2a706d2d));
		reset_i           = 1'b1;
		rs2fu_iss_vld_i   = 1'b0;
		rs2fu_sel_i       = FU_NONE;
		rs2fu_IR_i        = '0;
		prf2fu_ra_value_i = '0;
		prf2fu_rb_value_i = '0;
		rob2fu_NPC_i      = '0;
		rs2fu_dest_tag_i  = '0;
		rs2fu_rob_idx_i   = '0;
		rob_br_recovery_i = 1'b0;
		mem_rd_data_i     = '0;
		alu_v    = 1'b0;
		br_v     = 1'b0;
		br_rep   = 1'b0;
		st_pulse = 1'b0;
		mult_v   = '0;
		ld_ph    = 0;
		iss_v    = 1'b0;
		rec_cur  = 1'b0;
		foreach (inflight[i])
			inflight[i] = 1'b0;
		repeat (5) @(posedge clk);
		reset_i <= 1'b0;
		while (issued < NUM_ISSUES && cycles < CYCLE_LIMIT)
			run_cycle(1'b1);
		while (model_busy() && cycles < CYCLE_LIMIT)
			run_cycle(1'b0);  // drain
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: no end of run within %0d cycles", CYCLE_LIMIT);
			n_other_err++;
		end
		left = 0;
		foreach (inflight[i])
			left += int'(inflight[i]);
		if (left != 0) begin
			$display("%0d issued ROB indices never completed", left);
			n_other_err++;
		end
		$display("issued %0d, cycles %0d, value errors %0d, other errors %0d",
			issued, cycles, n_val_err, n_other_err);
		if (n_val_err + n_other_err == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+tb
common/fu_pkg.sv
common/fu_iss_if.sv
common/fu_wb_if.sv
verilog/fu_alu.sv
verilog/fu_br.sv
verilog/fu_mult.sv
verilog/fu_ldst.sv
verilog/fu_cdb_arb.sv
verilog/fu_main.sv
tb/tb_fu_main.sv
